// File: Bender.yml
package:
  name: hazard_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/hazard_pkg.sv
      - source/dst_tracker.sv
      - source/operand_bypass.sv
      - source/stall_flush_ctrl.sv
      - source/hazard_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_hazard_unit.sv

// File: source/dst_tracker.sv
`timescale 1ns/10ps
`default_nettype none
`include "hazard_macros.svh"

module dst_tracker (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire [`HZ_REG_W-1:0]  r_dst,
  input  wire                  dst_en,
  input  wire                  is_load,
  input  wire                  flush,
  output logic [`HZ_REG_W-1:0] dst_1,
  output logic                 ld_1,
  output logic [`HZ_REG_W-1:0] dst_2,
  output logic                 ld_2
);

  // A squashed or non-writing instruction is recorded as register zero,
  // which the operand checkers never match
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      dst_1 <= '0;
      ld_1  <= 1'b0;
      dst_2 <= '0;
      ld_2  <= 1'b0;
    end
    else
    begin
      if (dst_en && !flush)
      begin
        dst_1 <= r_dst;
        ld_1  <= is_load;
      end
      else
      begin
        dst_1 <= '0;
        ld_1  <= 1'b0;
      end
      dst_2 <= dst_1;
      ld_2  <= ld_1;
    end
  end

endmodule

`default_nettype wire

// File: source/hazard_macros.svh
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

// Register number width for a 32-entry register file
`define HZ_REG_W 5

// Source operands checked per decode instruction
`define HZ_NUM_SRC 2

// Flush lengths in cycles
`define HZ_JUMP_FLUSH 2
`define HZ_JUMP_BYP_FLUSH 3
`define HZ_BRANCH_FLUSH 2

`endif

// File: source/hazard_pkg.sv
`default_nettype none

package hazard_pkg;

  // Forwarding source for one operand
  typedef enum logic [1:0] {
    BYP_NONE = 2'd0,
    BYP_EX   = 2'd1,
    BYP_MEM  = 2'd2
  } bypass_sel_e;

  // Jump and branch flush sequencer
  typedef enum logic [1:0] {
    FL_IDLE       = 2'd0,
    FL_BR_RESOLVE = 2'd1,
    FL_FLUSH      = 2'd2
  } flush_state_e;

  // Control class of the instruction in decode
  typedef enum logic [1:0] {
    CK_NONE   = 2'd0,
    CK_JUMP   = 2'd1,
    CK_BRANCH = 2'd2
  } ctrl_kind_e;

endpackage

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "hazard_macros.svh"

module hazard_unit (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire                      is_b,
  input  wire                      is_j,
  input  wire                      is_load,
  input  wire                      is_m,
  input  wire                      is_d,
  input  wire                      dst_en,
  input  wire                      fin,
  input  wire                      pre_taken,
  input  wire                      real_taken,
  input  wire [`HZ_REG_W-1:0]      r_dst,
  input  wire [`HZ_REG_W-1:0]      r_src1,
  input  wire [`HZ_REG_W-1:0]      r_src2,
  input  wire                      f_cmiss,
  input  wire                      f_arrival,
  input  wire                      m_cmiss,
  input  wire                      m_arrival,
  output hazard_pkg::bypass_sel_e  src1_sel,
  output hazard_pkg::bypass_sel_e  src2_sel,
  output logic                     fd_st,
  output logic                     de_st,
  output logic                     em_st,
  output logic                     flush_o
);

  logic [`HZ_REG_W-1:0]    dst_1;
  logic [`HZ_REG_W-1:0]    dst_2;
  logic                    ld_1;
  logic                    flush;
  logic [`HZ_REG_W-1:0]    r_src [`HZ_NUM_SRC];
  hazard_pkg::bypass_sel_e sel [`HZ_NUM_SRC];
  logic [`HZ_NUM_SRC-1:0]  load_use;

  assign r_src[0] = r_src1;
  assign r_src[1] = r_src2;

  dst_tracker i_dst_tracker (
    .clk     (clk),
    .rstn    (rstn),
    .r_dst   (r_dst),
    .dst_en  (dst_en),
    .is_load (is_load),
    .flush   (flush),
    .dst_1   (dst_1),
    .ld_1    (ld_1),
    .dst_2   (dst_2),
    .ld_2    ()
  );

  for (genvar i = 0; i < `HZ_NUM_SRC; i++)
  begin : g_src
    operand_bypass i_operand_bypass (
      .r_src    (r_src[i]),
      .dst_1    (dst_1),
      .dst_2    (dst_2),
      .ld_1     (ld_1),
      .sel      (sel[i]),
      .load_use (load_use[i])
    );
  end

  stall_flush_ctrl i_stall_flush_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .sel        (sel),
    .load_use   (load_use),
    .is_j       (is_j),
    .is_b       (is_b),
    .is_m       (is_m),
    .is_d       (is_d),
    .fin        (fin),
    .pre_taken  (pre_taken),
    .real_taken (real_taken),
    .f_cmiss    (f_cmiss),
    .f_arrival  (f_arrival),
    .m_cmiss    (m_cmiss),
    .m_arrival  (m_arrival),
    .fd_st      (fd_st),
    .de_st      (de_st),
    .em_st      (em_st),
    .flush      (flush)
  );

  assign src1_sel = sel[0];
  assign src2_sel = sel[1];
  assign flush_o  = flush;

endmodule

`default_nettype wire

// File: source/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none
`include "hazard_macros.svh"

module operand_bypass (
  input  wire [`HZ_REG_W-1:0]      r_src,
  input  wire [`HZ_REG_W-1:0]      dst_1,
  input  wire [`HZ_REG_W-1:0]      dst_2,
  input  wire                      ld_1,
  output hazard_pkg::bypass_sel_e  sel,
  output logic                     load_use
);

  logic src_valid;
  logic hit_ex;
  logic hit_mem;

  // Register zero is hardwired and never forwarded
  assign src_valid = (r_src != '0);
  assign hit_ex    = src_valid && (r_src == dst_1);
  assign hit_mem   = src_valid && (r_src == dst_2);

  // The younger producer holds the newer value, so it wins
  always_comb
  begin
    if (hit_ex)
    begin
      sel = hazard_pkg::BYP_EX;
    end
    else if (hit_mem)
    begin
      sel = hazard_pkg::BYP_MEM;
    end
    else
    begin
      sel = hazard_pkg::BYP_NONE;
    end
  end

  // Load data is not ready until the end of the memory stage
  assign load_use = hit_ex && ld_1;

endmodule

`default_nettype wire

// File: source/stall_flush_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "hazard_macros.svh"

module stall_flush_ctrl (
  input  wire                      clk,
  input  wire                      rstn,
  input  hazard_pkg::bypass_sel_e  sel [`HZ_NUM_SRC],
  input  wire [`HZ_NUM_SRC-1:0]    load_use,
  input  wire                      is_j,
  input  wire                      is_b,
  input  wire                      is_m,
  input  wire                      is_d,
  input  wire                      fin,
  input  wire                      pre_taken,
  input  wire                      real_taken,
  input  wire                      f_cmiss,
  input  wire                      f_arrival,
  input  wire                      m_cmiss,
  input  wire                      m_arrival,
  output logic                     fd_st,
  output logic                     de_st,
  output logic                     em_st,
  output logic                     flush
);

  localparam int CNT_W = $clog2(`HZ_JUMP_BYP_FLUSH + 1);

  logic icmiss_keep;
  logic dcmiss_keep;
  logic linst_keep;
  logic icmiss_st;
  logic dcmiss_st;
  logic linst_st;
  logic ldhaz_st;
  logic any_byp;

  hazard_pkg::flush_state_e state;
  hazard_pkg::flush_state_e state_nxt;
  hazard_pkg::ctrl_kind_e   kind;
  logic [CNT_W-1:0]         cnt;
  logic [CNT_W-1:0]         cnt_nxt;
  logic                     bp_taken;
  logic                     bp_taken_nxt;

  // Miss and long-op latches keep a stall alive after the one-cycle request
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      icmiss_keep <= 1'b0;
      dcmiss_keep <= 1'b0;
      linst_keep  <= 1'b0;
    end
    else
    begin
      if (f_cmiss)
        icmiss_keep <= 1'b1;
      else if (f_arrival)
        icmiss_keep <= 1'b0;

      if (m_cmiss)
        dcmiss_keep <= 1'b1;
      else if (m_arrival)
        dcmiss_keep <= 1'b0;

      if ((is_m || is_d) && !flush)
        linst_keep <= 1'b1;
      else if (fin)
        linst_keep <= 1'b0;
    end
  end

  assign icmiss_st = !f_arrival && (f_cmiss || icmiss_keep);
  assign dcmiss_st = !m_arrival && (m_cmiss || dcmiss_keep);
  assign linst_st  = !(fin || flush) && (is_m || is_d || linst_keep);
  assign ldhaz_st  = |load_use;

  assign fd_st = icmiss_st || dcmiss_st || linst_st || ldhaz_st;
  assign de_st = ldhaz_st || dcmiss_st;
  assign em_st = dcmiss_st;

  // A jump whose operand is forwarded resolves one stage later
  always_comb
  begin
    any_byp = 1'b0;
    for (int i = 0; i < `HZ_NUM_SRC; i++)
    begin
      if (sel[i] != hazard_pkg::BYP_NONE)
        any_byp = 1'b1;
    end
  end

  always_comb
  begin
    case (state)
      hazard_pkg::FL_BR_RESOLVE: flush = bp_taken || real_taken;
      hazard_pkg::FL_FLUSH:      flush = 1'b1;
      default:                   flush = 1'b0;
    endcase
  end

  // Decode instructions already being squashed cannot redirect
  always_comb
  begin
    if (flush)
      kind = hazard_pkg::CK_NONE;
    else if (is_j)
      kind = hazard_pkg::CK_JUMP;
    else if (is_b)
      kind = hazard_pkg::CK_BRANCH;
    else
      kind = hazard_pkg::CK_NONE;
  end

  always_comb
  begin
    state_nxt    = state;
    cnt_nxt      = cnt;
    bp_taken_nxt = bp_taken;
    case (state)
      hazard_pkg::FL_IDLE:
      begin
        if (kind == hazard_pkg::CK_JUMP)
        begin
          state_nxt = hazard_pkg::FL_FLUSH;
          cnt_nxt   = any_byp ? CNT_W'(`HZ_JUMP_BYP_FLUSH) : CNT_W'(`HZ_JUMP_FLUSH);
        end
        else if (kind == hazard_pkg::CK_BRANCH)
        begin
          state_nxt    = hazard_pkg::FL_BR_RESOLVE;
          bp_taken_nxt = pre_taken;
        end
      end
      hazard_pkg::FL_BR_RESOLVE:
      begin
        // The resolve cycle itself counts as the first flush cycle
        if (flush)
        begin
          state_nxt = hazard_pkg::FL_FLUSH;
          cnt_nxt   = CNT_W'(`HZ_BRANCH_FLUSH - 1);
        end
        else
        begin
          state_nxt = hazard_pkg::FL_IDLE;
        end
      end
      hazard_pkg::FL_FLUSH:
      begin
        cnt_nxt = cnt - 1'b1;
        if (cnt == CNT_W'(1))
          state_nxt = hazard_pkg::FL_IDLE;
      end
      default:
      begin
        state_nxt = hazard_pkg::FL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstn)
      state <= hazard_pkg::FL_IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk)
  begin
    cnt      <= cnt_nxt;
    bp_taken <= bp_taken_nxt;
  end

endmodule

`default_nettype wire

// File: tb/tb_hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "hazard_macros.svh"

module tb_hazard_unit;

  localparam int NUM_CYCLES  = 3000;
  localparam int RESET_LIMIT = 10;
  localparam int DRAIN_LIMIT = 12;

  logic                    clk;
  logic                    rstn;
  logic                    is_b;
  logic                    is_j;
  logic                    is_load;
  logic                    is_m;
  logic                    is_d;
  logic                    dst_en;
  logic                    fin;
  logic                    pre_taken;
  logic                    real_taken;
  logic [`HZ_REG_W-1:0]    r_dst;
  logic [`HZ_REG_W-1:0]    r_src1;
  logic [`HZ_REG_W-1:0]    r_src2;
  logic                    f_cmiss;
  logic                    f_arrival;
  logic                    m_cmiss;
  logic                    m_arrival;
  hazard_pkg::bypass_sel_e src1_sel;
  hazard_pkg::bypass_sel_e src2_sel;
  logic                    fd_st;
  logic                    de_st;
  logic                    em_st;
  logic                    flush_o;

  // Reference model state
  logic [`HZ_REG_W-1:0]     m_dst_1;
  logic [`HZ_REG_W-1:0]     m_dst_2;
  logic                     m_ld_1;
  logic                     m_ic_keep;
  logic                     m_dc_keep;
  logic                     m_lo_keep;
  logic                     m_bp_taken;
  hazard_pkg::flush_state_e m_state;
  int                       m_cnt;
  int                       i_wait;
  int                       d_wait;
  int unsigned              lcg_state;

  hazard_unit i_dut (
    .clk        (clk),
    .rstn       (rstn),
    .is_b       (is_b),
    .is_j       (is_j),
    .is_load    (is_load),
    .is_m       (is_m),
    .is_d       (is_d),
    .dst_en     (dst_en),
    .fin        (fin),
    .pre_taken  (pre_taken),
    .real_taken (real_taken),
    .r_dst      (r_dst),
    .r_src1     (r_src1),
    .r_src2     (r_src2),
    .f_cmiss    (f_cmiss),
    .f_arrival  (f_arrival),
    .m_cmiss    (m_cmiss),
    .m_arrival  (m_arrival),
    .src1_sel   (src1_sel),
    .src2_sel   (src2_sel),
    .fd_st      (fd_st),
    .de_st      (de_st),
    .em_st      (em_st),
    .flush_o    (flush_o)
  );

  always #5 clk = ~clk;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  function automatic hazard_pkg::bypass_sel_e expected_sel(input logic [`HZ_REG_W-1:0] src);
    if (src != '0 && src == m_dst_1)
      return hazard_pkg::BYP_EX;
    else if (src != '0 && src == m_dst_2)
      return hazard_pkg::BYP_MEM;
    else
      return hazard_pkg::BYP_NONE;
  endfunction

  task automatic check_sel(input string name, input hazard_pkg::bypass_sel_e exp,
                           input hazard_pkg::bypass_sel_e act);
    if (exp !== act)
    begin
      $display("FAIL time=%0t signal=%s expected=%s actual=%s",
               $time, name, exp.name(), act.name());
      $display("Regression failed");
      $fatal(1, "Bypass select mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("FAIL time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      $display("Regression failed");
      $fatal(1, "Strobe mismatch on %s", name);
    end
  endtask

  // Each arrival comes 1 to 6 cycles after its miss
  task automatic miss_sequence(input bit allow_new, inout int wait_cnt,
                               output logic miss, output logic arrival);
    miss    = 1'b0;
    arrival = 1'b0;
    if (wait_cnt > 0)
    begin
      wait_cnt--;
      if (wait_cnt == 0)
        arrival = 1'b1;
    end
    else if (allow_new && (next_rand() % 10 == 0))
    begin
      miss     = 1'b1;
      wait_cnt = 1 + int'(next_rand() % 6);
    end
  endtask

  task automatic drive_inputs(input bit allow_new);
    int unsigned cls;
    cls       = next_rand() % 16;
    is_j      = (cls < 2);
    is_b      = (cls >= 2 && cls < 4);
    is_m      = (cls == 4);
    is_d      = (cls == 5);
    is_load   = (cls >= 6 && cls < 9);
    dst_en    = is_load || (next_rand() % 4 != 0);
    r_dst     = `HZ_REG_W'(next_rand() % 6);
    r_src1    = `HZ_REG_W'(next_rand() % 6);
    r_src2    = `HZ_REG_W'(next_rand() % 6);
    pre_taken = next_rand() % 2 == 1;
    real_taken = next_rand() % 2 == 1;
    fin       = (m_lo_keep && (next_rand() % 4 == 0)) || (next_rand() % 32 == 0);
    miss_sequence(allow_new, i_wait, f_cmiss, f_arrival);
    miss_sequence(allow_new, d_wait, m_cmiss, m_arrival);
  endtask

  task automatic check_and_step();
    hazard_pkg::bypass_sel_e e_sel1;
    hazard_pkg::bypass_sel_e e_sel2;
    hazard_pkg::ctrl_kind_e  kind;
    logic                    e_ldhaz;
    logic                    e_ic;
    logic                    e_dc;
    logic                    e_lo;
    logic                    e_flush;
    logic                    any_byp;
    e_sel1  = expected_sel(r_src1);
    e_sel2  = expected_sel(r_src2);
    e_ldhaz = m_ld_1 && (e_sel1 == hazard_pkg::BYP_EX || e_sel2 == hazard_pkg::BYP_EX);
    e_flush = (m_state == hazard_pkg::FL_FLUSH) ||
              (m_state == hazard_pkg::FL_BR_RESOLVE && (m_bp_taken || real_taken));
    e_ic    = !f_arrival && (f_cmiss || m_ic_keep);
    e_dc    = !m_arrival && (m_cmiss || m_dc_keep);
    e_lo    = !fin && !e_flush && (is_m || is_d || m_lo_keep);
    check_sel("src1_sel", e_sel1, src1_sel);
    check_sel("src2_sel", e_sel2, src2_sel);
    check_bit("fd_st", e_ic || e_dc || e_lo || e_ldhaz, fd_st);
    check_bit("de_st", e_ldhaz || e_dc, de_st);
    check_bit("em_st", e_dc, em_st);
    check_bit("flush_o", e_flush, flush_o);

    // Advance the model to the state after the coming edge
    if (e_flush)
      kind = hazard_pkg::CK_NONE;
    else if (is_j)
      kind = hazard_pkg::CK_JUMP;
    else if (is_b)
      kind = hazard_pkg::CK_BRANCH;
    else
      kind = hazard_pkg::CK_NONE;
    any_byp = (e_sel1 != hazard_pkg::BYP_NONE) || (e_sel2 != hazard_pkg::BYP_NONE);
    m_dst_2 = m_dst_1;
    m_dst_1 = (dst_en && !e_flush) ? r_dst : '0;
    m_ld_1  = dst_en && !e_flush && is_load;
    if (f_cmiss)
      m_ic_keep = 1'b1;
    else if (f_arrival)
      m_ic_keep = 1'b0;
    if (m_cmiss)
      m_dc_keep = 1'b1;
    else if (m_arrival)
      m_dc_keep = 1'b0;
    if ((is_m || is_d) && !e_flush)
      m_lo_keep = 1'b1;
    else if (fin)
      m_lo_keep = 1'b0;
    case (m_state)
      hazard_pkg::FL_IDLE:
      begin
        if (kind == hazard_pkg::CK_JUMP)
        begin
          m_state = hazard_pkg::FL_FLUSH;
          m_cnt   = any_byp ? `HZ_JUMP_BYP_FLUSH : `HZ_JUMP_FLUSH;
        end
        else if (kind == hazard_pkg::CK_BRANCH)
        begin
          m_state    = hazard_pkg::FL_BR_RESOLVE;
          m_bp_taken = pre_taken;
        end
      end
      hazard_pkg::FL_BR_RESOLVE:
      begin
        if (e_flush)
        begin
          m_state = hazard_pkg::FL_FLUSH;
          m_cnt   = `HZ_BRANCH_FLUSH - 1;
        end
        else
          m_state = hazard_pkg::FL_IDLE;
      end
      default:
      begin
        if (m_cnt == 1)
          m_state = hazard_pkg::FL_IDLE;
        m_cnt--;
      end
    endcase
  endtask

  task automatic run_cycle(input bit allow_new);
    @(posedge clk);
    #1;
    drive_inputs(allow_new);
    #4;
    check_and_step();
  endtask

  task automatic wait_idle_after_reset();
    int n;
    n = 0;
    while (({fd_st, de_st, em_st, flush_o} !== 4'b0) && n < RESET_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if ({fd_st, de_st, em_st, flush_o} !== 4'b0)
    begin
      $display("Regression failed");
      $fatal(1, "Stall and flush outputs did not go idle after reset");
    end
  endtask

  // Let outstanding misses see their arrival before ending the run
  task automatic drain_misses();
    int n;
    n = 0;
    while ((i_wait != 0 || d_wait != 0) && n < DRAIN_LIMIT)
    begin
      run_cycle(1'b0);
      n++;
    end
    if (i_wait != 0 || d_wait != 0)
    begin
      $display("Regression failed");
      $fatal(1, "A cache arrival did not come within the cycle limit");
    end
  endtask

  initial
  begin
    repeat (NUM_CYCLES + 200) @(posedge clk);
    $display("Regression failed");
    $fatal(1, "Simulation did not finish within the cycle limit");
  end

  initial
  begin
    clk        = 1'b0;
    rstn       = 1'b0;
    {is_b, is_j, is_load, is_m, is_d, dst_en, fin} = '0;
    {pre_taken, real_taken} = '0;
    {f_cmiss, f_arrival, m_cmiss, m_arrival} = '0;
    r_dst      = '0;
    r_src1     = '0;
    r_src2     = '0;
    lcg_state  = 32'd56724;
    i_wait     = 0;
    d_wait     = 0;
    m_dst_1    = '0;
    m_dst_2    = '0;
    m_ld_1     = 1'b0;
    m_ic_keep  = 1'b0;
    m_dc_keep  = 1'b0;
    m_lo_keep  = 1'b0;
    m_bp_taken = 1'b0;
    m_state    = hazard_pkg::FL_IDLE;
    m_cnt      = 0;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    wait_idle_after_reset();
    for (int n = 0; n < NUM_CYCLES; n++)
      run_cycle(1'b1);
    drain_misses();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/hazard_pkg.sv
source/dst_tracker.sv
source/operand_bypass.sv
source/stall_flush_ctrl.sv
source/hazard_unit.sv
tb/tb_hazard_unit.sv
